//--- Bender.yml
package:
  name: shared_mem

sources:
  # packages first, then the pipeline stages and the top level
  - client_pkg.sv
  - bus_pkg.sv
  - request_handler.sv
  - wb_master.sv
  - wb_sram.sv
  - shared_mem_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - shared_mem_checker.sv
      - shared_mem_tb.sv

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

  // client request plus the tag of the client that issued it
  typedef struct packed {
    client_pkg::client_req_t     req;
    client_pkg::current_client_t tag;
  } mem_req_t;

  // one-cycle response from the bus master, 35 bits
  typedef struct packed {
    logic                        valid;
    client_pkg::current_client_t tag;  // routes data back
    logic [31:0]                 dat;
  } mem_rsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

//--- client_pkg.sv
`default_nettype none

package client_pkg;

  // who owns the memory bus this cycle, also used as request tag
  typedef enum logic [1:0] {
    NONE = 2'd0,
    CPU  = 2'd1,
    VGA  = 2'd2,
    UART = 2'd3
  } current_client_t;

  // vga claim on memory
  typedef enum logic [1:0] {
    INACTIVE = 2'd0,
    READY    = 2'd1, // scan-out about to start
    ACTIVE   = 2'd2
  } vga_state_t;

  // one request per client, 70 bits
  typedef struct packed {
    logic        write;
    logic        read;
    logic [31:0] adr;  // word address
    logic [31:0] dat;
    logic [3:0]  sel;  // byte lanes
  } client_req_t;

  // response back to a client, 33 bits
  typedef struct packed {
    logic        valid;
    logic [31:0] dat;
  } client_rsp_t;

endpackage

`default_nettype wire

//--- request_handler.sv
`timescale 1ns/1ps
`default_nettype none

module request_handler (
  input  logic                     clk,
  input  logic                     nRst,

  // client side
  input  client_pkg::vga_state_t   vga_state,
  input  client_pkg::client_req_t  cpu_req,
  input  client_pkg::client_req_t  vga_req,
  input  client_pkg::client_req_t  uart_req,
  output logic                     cpu_enable,
  output logic                     uart_enable,
  output logic                     vga_grant,
  output client_pkg::client_rsp_t  cpu_rsp,
  output client_pkg::client_rsp_t  vga_rsp,
  output client_pkg::client_rsp_t  uart_rsp,

  // memory side
  output bus_pkg::mem_req_t        mem_req,
  input  logic                     busy,
  input  bus_pkg::mem_rsp_t        mem_rsp
);

  import client_pkg::*;

  current_client_t current_client;

  // vga always wins while it claims memory, uart gets the slot right after
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      current_client <= NONE;
    end else begin
      if (vga_state == READY || vga_state == ACTIVE) begin
        current_client <= VGA;
      end else if (current_client == VGA) begin
        current_client <= UART;
      end else begin
        current_client <= CPU;
      end
    end
  end

  // forward the selected request while the bus master is free
  always_comb begin
    cpu_enable  = 1'b0;
    uart_enable = 1'b0;
    vga_grant   = 1'b0;
    mem_req     = '0; // read and write low, tag NONE

    if (!busy) begin
      case (current_client)
        CPU: begin
          cpu_enable  = 1'b1;
          mem_req.req = cpu_req;
          mem_req.tag = CPU;
        end

        VGA: begin
          vga_grant   = 1'b1;
          mem_req.req = vga_req;
          mem_req.tag = VGA;
        end

        UART: begin
          uart_enable = 1'b1;
          mem_req.req = uart_req;
          mem_req.tag = UART;
        end

        default: begin
          mem_req = '0; // nobody selected yet
        end
      endcase
    end
  end

  // steer returning data to the tagged client
  always_comb begin
    cpu_rsp  = '0;
    vga_rsp  = '0;
    uart_rsp = '0;

    if (mem_rsp.valid) begin
      case (mem_rsp.tag)
        CPU: begin
          cpu_rsp.valid = 1'b1;
          cpu_rsp.dat   = mem_rsp.dat;
        end

        VGA: begin
          vga_rsp.valid = 1'b1;
          vga_rsp.dat   = mem_rsp.dat;
        end

        UART: begin
          uart_rsp.valid = 1'b1;
          uart_rsp.dat   = mem_rsp.dat;
        end

        default: begin
          cpu_rsp = '0; // untagged response is dropped
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- shared_mem.f
client_pkg.sv
bus_pkg.sv
request_handler.sv
wb_master.sv
wb_sram.sv
shared_mem_top.sv
shared_mem_checker.sv
shared_mem_tb.sv

//--- shared_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module shared_mem_checker (
  input logic                        clk,
  input logic                        nRst,
  input logic                        cpu_enable,
  input logic                        uart_enable,
  input logic                        vga_grant,
  input logic                        busy,
  input client_pkg::current_client_t current_client,
  input bus_pkg::wb_m2s_t            wb,
  input logic                        ack,
  input logic                        accept,
  input logic                        rsp_valid
);

  import client_pkg::*;

  int   assert_fails = 0;
  logic pending; // accepted request still waiting for its response

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1; // a new request may start in the response cycle
    end else if (rsp_valid) begin
      pending <= 1'b0;
    end
  end

  single_owner: assert property (@(posedge clk) disable iff (!nRst)
    $onehot0({cpu_enable, uart_enable, vga_grant}))
    else begin
      $error("more than one client enabled at once");
      assert_fails++;
    end

  quiet_while_busy: assert property (@(posedge clk) disable iff (!nRst)
    busy |-> !(cpu_enable || uart_enable || vga_grant))
    else begin
      $error("client enabled while the bus master is busy");
      assert_fails++;
    end

  uart_after_vga: assert property (@(posedge clk) disable iff (!nRst)
    uart_enable |-> ($past(current_client) == VGA))
    else begin
      $error("uart enabled without a preceding vga cycle");
      assert_fails++;
    end

  stb_needs_cyc: assert property (@(posedge clk) disable iff (!nRst)
    wb.stb |-> wb.cyc)
    else begin
      $error("stb high without cyc");
      assert_fails++;
    end

  stb_until_ack: assert property (@(posedge clk) disable iff (!nRst)
    (wb.stb && !ack) |=> wb.stb)
    else begin
      $error("stb dropped before ack");
      assert_fails++;
    end

  one_rsp_per_req: assert property (@(posedge clk) disable iff (!nRst)
    rsp_valid |-> pending)
    else begin
      $error("response without an outstanding request");
      assert_fails++;
    end

endmodule

bind request_handler shared_mem_checker u_grant_checker (
  .clk            (clk),
  .nRst           (nRst),
  .cpu_enable     (cpu_enable),
  .uart_enable    (uart_enable),
  .vga_grant      (vga_grant),
  .busy           (busy),
  .current_client (current_client),
  .wb             ('0),
  .ack            (1'b0),
  .accept         (1'b0),
  .rsp_valid      (1'b0)
);

bind wb_master shared_mem_checker u_bus_checker (
  .clk            (clk),
  .nRst           (nRst),
  .cpu_enable     (1'b0),
  .uart_enable    (1'b0),
  .vga_grant      (1'b0),
  .busy           (busy),
  .current_client (client_pkg::NONE),
  .wb             (wb_o),
  .ack            (wb_i.ack),
  .accept         (accept),
  .rsp_valid      (rsp_valid)
);

`default_nettype wire

//--- shared_mem_input.txt
# client: 1 cpu, 2 vga, 3 uart; rw: 1 write, 0 read; vga_state: 0 inactive, 1 ready, 2 active
# columns: client rw adr data sel vga_state expected (hex), expected is checked on reads only
1 1 00000010 11223344 f 0 00000000
1 1 00000011 aabbccdd f 0 00000000
1 1 00000012 cafef00d f 0 00000000
1 1 00000413 deadbeef f 0 00000000
1 1 00000010 000000ee 1 0 00000000
1 1 00000011 5a5a0000 c 0 00000000
1 1 00000012 00990000 4 0 00000000
1 1 00000013 0000ab00 2 0 00000000
1 0 00000010 00000000 f 0 112233ee
1 0 00000011 00000000 f 0 5a5accdd
1 0 00000012 00000000 f 0 ca99f00d
1 0 00000013 00000000 f 0 deadabef
2 0 00000010 00000000 f 1 112233ee
2 0 00000011 00000000 f 2 5a5accdd
2 0 00000412 00000000 f 2 ca99f00d
2 0 00000013 00000000 f 1 deadabef
1 0 00000010 00000000 f 2 112233ee
1 1 00000014 01234567 f 1 00000000
3 1 00000020 01020304 f 1 00000000
3 1 00000021 05060708 f 1 00000000
3 1 00000022 090a0b0c f 2 00000000
3 1 00000023 0d0e0f10 f 1 00000000
3 1 00000024 11121314 f 2 00000000
3 1 00000025 15161718 f 1 00000000
1 0 00000020 00000000 f 0 01020304
1 0 00000021 00000000 f 0 05060708
1 0 00000022 00000000 f 0 090a0b0c
1 0 00000023 00000000 f 0 0d0e0f10
1 0 00000024 00000000 f 0 11121314
1 0 00000025 00000000 f 0 15161718
3 0 00000014 00000000 f 1 01234567
1 0 00000014 00000000 f 0 01234567
2 0 00000020 00000000 f 2 01020304

//--- shared_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module shared_mem_tb;

  import client_pkg::*;

  localparam int MEM_WORDS   = 1024;
  localparam int WAIT_STATES = 1;
  localparam int TIMEOUT     = 50; // cycles per wait

  logic        clk;
  logic        nRst;
  client_req_t cpu_req;
  client_req_t vga_req;
  client_req_t uart_req;
  vga_state_t  vga_state;
  logic        cpu_enable;
  logic        uart_enable;
  logic        vga_grant;
  client_rsp_t cpu_rsp;
  client_rsp_t vga_rsp;
  client_rsp_t uart_rsp;

  logic [31:0] model [MEM_WORDS]; // expected memory contents
  int          errors;
  int          timeouts;
  int          txns;
  int          assert_fails;
  integer      seed;

  shared_mem_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) DUT (
    .clk         (clk),
    .nRst        (nRst),
    .cpu_req     (cpu_req),
    .vga_req     (vga_req),
    .uart_req    (uart_req),
    .vga_state   (vga_state),
    .cpu_enable  (cpu_enable),
    .uart_enable (uart_enable),
    .vga_grant   (vga_grant),
    .cpu_rsp     (cpu_rsp),
    .vga_rsp     (vga_rsp),
    .uart_rsp    (uart_rsp)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic string client_name(current_client_t c);
    case (c)
      CPU:     return "cpu";
      VGA:     return "vga";
      UART:    return "uart";
      default: return "none";
    endcase
  endfunction

  function automatic logic enable_of(current_client_t c);
    case (c)
      CPU:     return cpu_enable;
      VGA:     return vga_grant;
      UART:    return uart_enable;
      default: return 1'b0;
    endcase
  endfunction

  function automatic client_rsp_t rsp_of(current_client_t c);
    case (c)
      CPU:     return cpu_rsp;
      VGA:     return vga_rsp;
      UART:    return uart_rsp;
      default: return '0;
    endcase
  endfunction

  // which client the enables point at, NONE if all low
  function automatic current_client_t enabled_client();
    if (cpu_enable) return CPU;
    if (vga_grant) return VGA;
    if (uart_enable) return UART;
    return NONE;
  endfunction

  task automatic check_rsp(string name, client_rsp_t got, client_rsp_t exp, bit with_data);
    if (got.valid !== exp.valid) begin
      $display("FAILED t=%0t %s.valid got %b expected %b", $time, name, got.valid, exp.valid);
      errors++;
    end else if (with_data && got.dat !== exp.dat) begin
      $display("FAILED t=%0t %s.dat got %h expected %h", $time, name, got.dat, exp.dat);
      errors++;
    end
  endtask

  task automatic check_client(string name, current_client_t got, current_client_t exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_no_rsp();
    current_client_t k;
    for (int n = 1; n < 4; n++) begin
      k = current_client_t'(n);
      check_rsp({client_name(k), "_rsp"}, rsp_of(k), '0, 1'b1);
    end
  endtask

  task automatic set_req(current_client_t c, client_req_t r);
    case (c)
      CPU:     cpu_req = r;
      VGA:     vga_req = r;
      UART:    uart_req = r;
      default: ;
    endcase
  endtask

  task automatic idle_reqs();
    cpu_req  = '0;
    vga_req  = '0;
    uart_req = '0;
  endtask

  // one request from one client, called and returning on a falling edge
  task automatic run_txn(current_client_t c, logic we, logic [31:0] adr, logic [31:0] dat,
                         logic [3:0] sel, vga_state_t vstate, logic [31:0] expv);
    client_req_t     r;
    client_rsp_t     exp;
    current_client_t k;
    int              waited;
    int              hold;
    int              idx;
    bit              accepted;
    bit              done;

    r.write = we;
    r.read  = !we;
    r.adr   = adr;
    r.dat   = dat;
    r.sel   = sel;
    idx     = int'(adr % MEM_WORDS);
    hold    = (c == CPU) ? 3 : 1; // cycles the vga claim is kept
    txns++;

    // vga claim takes effect on the next edge, ahead of the request
    vga_state = vstate;
    if (c != VGA && vstate != INACTIVE) @(negedge clk);
    set_req(c, r);

    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < TIMEOUT) begin
      if (c != VGA && vstate != INACTIVE && waited < hold) begin
        check_client("granted client", enabled_client(), VGA);
        if (waited == hold - 1) vga_state = INACTIVE; // release the claim
      end
      if (enable_of(c)) begin
        check_client("granted client", enabled_client(), c);
        accepted = 1'b1;
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    if (!accepted) begin
      $display("timeout: %s request at address %h was never enabled", client_name(c), adr);
      timeouts++;
      idle_reqs();
      return;
    end

    @(negedge clk);
    idle_reqs(); // taken on the rising edge just passed

    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      if (cpu_rsp.valid || vga_rsp.valid || uart_rsp.valid) begin
        done = 1'b1;
      end else begin
        if (enabled_client() != NONE) begin
          $display("%s enable high at %0t while a transfer is outstanding",
                   client_name(enabled_client()), $time);
          errors++;
        end
        @(negedge clk);
        waited++;
      end
    end
    if (!done) begin
      $display("timeout: no response for %s request at address %h", client_name(c), adr);
      timeouts++;
      return;
    end

    exp.valid = 1'b1;
    exp.dat   = 32'b0;
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (sel[i]) model[idx][8*i +: 8] = dat[8*i +: 8];
      end
    end else begin
      if (model[idx] !== expv) begin
        $display("input file expects %h at address %h but the memory model holds %h",
                 expv, adr, model[idx]);
        errors++;
      end
      exp.dat = model[idx];
    end

    for (int n = 1; n < 4; n++) begin
      k = current_client_t'(n);
      if (k == c) check_rsp({client_name(k), "_rsp"}, rsp_of(k), exp, !we);
      else check_rsp({client_name(k), "_rsp"}, rsp_of(k), '0, 1'b1);
    end
    @(negedge clk);
    check_no_rsp(); // response lasts one cycle only
  endtask

  // a few idle cycles with random vga claims between transactions
  task automatic idle_filler();
    int n;
    n = $unsigned($random(seed)) % 3;
    for (int i = 0; i < n; i++) begin
      vga_state = vga_state_t'($unsigned($random(seed)) % 3);
      @(negedge clk);
      check_no_rsp();
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    string       line;
    logic [31:0] f_client;
    logic [31:0] f_rw;
    logic [31:0] f_adr;
    logic [31:0] f_dat;
    logic [31:0] f_sel;
    logic [31:0] f_vs;
    logic [31:0] f_exp;

    errors    = 0;
    timeouts  = 0;
    txns      = 0;
    seed      = 32'h29ff;
    nRst      = 1'b0;
    vga_state = INACTIVE;
    idle_reqs();

    repeat (2) @(posedge clk);
    @(negedge clk);
    nRst = 1'b1;
    check_client("granted client", enabled_client(), NONE); // nobody selected yet
    check_no_rsp();
    @(negedge clk);

    fd = $fopen("shared_mem_input.txt", "r");
    if (fd == 0) begin
      $display("could not open shared_mem_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc == 0) break;
        if (line.len() < 2 || line[0] == "#") continue;
        rc = $sscanf(line, "%h %h %h %h %h %h %h",
                     f_client, f_rw, f_adr, f_dat, f_sel, f_vs, f_exp);
        if (rc != 7) begin
          $display("malformed line in shared_mem_input.txt: %s", line);
          errors++;
          continue;
        end
        run_txn(current_client_t'(f_client[1:0]), f_rw[0], f_adr, f_dat, f_sel[3:0],
                vga_state_t'(f_vs[1:0]), f_exp);
        idle_filler();
      end
      $fclose(fd);
    end

    assert_fails = DUT.u_request_handler.u_grant_checker.assert_fails
                 + DUT.u_wb_master.u_bus_checker.assert_fails;
    $display("checks failed: %0d, assertion failures: %0d, timeouts: %0d, transactions: %0d",
             errors, assert_fails, timeouts, txns);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- shared_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module shared_mem_top #(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_STATES = 1
) (
  input  logic                    clk,
  input  logic                    nRst,

  input  client_pkg::client_req_t cpu_req,
  input  client_pkg::client_req_t vga_req,
  input  client_pkg::client_req_t uart_req,
  input  client_pkg::vga_state_t  vga_state,

  output logic                    cpu_enable,
  output logic                    uart_enable,
  output logic                    vga_grant,
  output client_pkg::client_rsp_t cpu_rsp,
  output client_pkg::client_rsp_t vga_rsp,
  output client_pkg::client_rsp_t uart_rsp
);

  import bus_pkg::*;

  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic     busy;
  wb_m2s_t  wb_m2s;
  wb_s2m_t  wb_s2m;

  // client arbitration and response steering
  request_handler u_request_handler (
    .clk         (clk),
    .nRst        (nRst),
    .vga_state   (vga_state),
    .cpu_req     (cpu_req),
    .vga_req     (vga_req),
    .uart_req    (uart_req),
    .cpu_enable  (cpu_enable),
    .uart_enable (uart_enable),
    .vga_grant   (vga_grant),
    .cpu_rsp     (cpu_rsp),
    .vga_rsp     (vga_rsp),
    .uart_rsp    (uart_rsp),
    .mem_req     (mem_req),
    .busy        (busy),
    .mem_rsp     (mem_rsp)
  );

  wb_master u_wb_master (
    .clk     (clk),
    .nRst    (nRst),
    .mem_req (mem_req),
    .busy    (busy),
    .mem_rsp (mem_rsp),
    .wb_o    (wb_m2s),
    .wb_i    (wb_s2m)
  );

  wb_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_wb_sram (
    .clk  (clk),
    .nRst (nRst),
    .wb_i (wb_m2s),
    .wb_o (wb_s2m)
  );

endmodule

`default_nettype wire

//--- wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_master (
  input  logic              clk,
  input  logic              nRst,

  // from the request handler
  input  bus_pkg::mem_req_t mem_req,
  output logic              busy,
  output bus_pkg::mem_rsp_t mem_rsp,

  // wishbone classic master port
  output bus_pkg::wb_m2s_t  wb_o,
  input  bus_pkg::wb_s2m_t  wb_i
);

  import bus_pkg::*;

  typedef enum logic {
    IDLE  = 1'b0,
    CYCLE = 1'b1
  } state_t;

  state_t      state;
  mem_req_t    req_q;     // held for the whole bus cycle
  logic        rsp_valid;
  logic [31:0] rsp_dat;
  logic        accept;

  assign accept = (state == IDLE) && (mem_req.req.read || mem_req.req.write);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state     <= IDLE;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0; // single cycle pulse
      case (state)
        IDLE: begin
          if (accept) state <= CYCLE;
        end

        CYCLE: begin
          if (wb_i.ack) begin
            state     <= IDLE;
            rsp_valid <= 1'b1;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) req_q <= mem_req;
    if (state == CYCLE && wb_i.ack) rsp_dat <= wb_i.dat;
  end

  assign busy = (state == CYCLE);

  always_comb begin
    wb_o.cyc = (state == CYCLE);
    wb_o.stb = (state == CYCLE); // classic, no pipelining
    wb_o.we  = req_q.req.write;
    wb_o.adr = req_q.req.adr;
    wb_o.dat = req_q.req.dat;
    wb_o.sel = req_q.req.sel;
  end

  // req_q only changes after the response cycle, so its tag is still valid
  always_comb begin
    mem_rsp.valid = rsp_valid;
    mem_rsp.tag   = req_q.tag;
    mem_rsp.dat   = rsp_dat;
  end

endmodule

`default_nettype wire

//--- wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
  parameter int MEM_WORDS   = 1024,
  parameter int WAIT_STATES = 1
) (
  input  logic             clk,
  input  logic             nRst,
  input  bus_pkg::wb_m2s_t wb_i,
  output bus_pkg::wb_s2m_t wb_o
);

  localparam int ADR_W = $clog2(MEM_WORDS);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [31:0]      mem [MEM_WORDS];
  logic [ADR_W-1:0] idx;
  logic [CNT_W-1:0] wait_cnt; // cycles stb has been high so far
  logic             ack;

  // word address wraps at the memory depth
  assign idx = ADR_W'(wb_i.adr % 32'(MEM_WORDS));

  // ack in the (WAIT_STATES+1)th strobe cycle
  assign ack = wb_i.cyc && wb_i.stb && (wait_cnt == CNT_W'(WAIT_STATES));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      wait_cnt <= '0;
    end else begin
      if (ack) begin
        wait_cnt <= '0;
      end else if (wb_i.cyc && wb_i.stb) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0; // master abandoned the cycle
      end
    end
  end

  // byte masked write on the ack cycle
  always_ff @(posedge clk) begin
    if (ack && wb_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (wb_i.sel[i]) mem[idx][8*i +: 8] <= wb_i.dat[8*i +: 8];
      end
    end
  end

  always_comb begin
    wb_o.ack = ack;
    wb_o.dat = (ack && !wb_i.we) ? mem[idx] : 32'b0; // read data only with ack
  end

endmodule

`default_nettype wire
